// ==== hdl/db_stash_cfg.svh ====
`ifndef DB_STASH_CFG_SVH
`define DB_STASH_CFG_SVH

// --------------------------------------------------
// Stash geometry
// --------------------------------------------------
`define DB_STASH_SIZE 8
`define DB_KEY_W      8
`define DB_VALUE_W    16

// Room for 0 through DB_STASH_SIZE
`define DB_FILL_W     ($clog2(`DB_STASH_SIZE) + 1)

// --------------------------------------------------
// APB register byte offsets
// --------------------------------------------------
`define DB_REG_KEY      8'h00
`define DB_REG_VALUE    8'h04
`define DB_REG_CMD      8'h08
`define DB_REG_STATUS   8'h0C
`define DB_REG_RD_KEY   8'h10
`define DB_REG_RD_VALUE 8'h14

`endif

// ==== hdl/apb_pkg.sv ====
`default_nettype none

package apb_pkg;

    // --------------------------------------------------
    // APB field widths
    // --------------------------------------------------
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Host to slave
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // Slave to host, pslverr only meaningful with pready
    typedef struct packed {
        logic      pready;
        apb_data_t prdata;
        logic      pslverr;
    } apb_rsp_t;

endpackage : apb_pkg

`default_nettype wire

// ==== hdl/db_pkg.sv ====
`default_nettype none

`include "db_stash_cfg.svh"

package db_pkg;

    // --------------------------------------------------
    // Payload widths
    // --------------------------------------------------
    typedef logic [`DB_KEY_W-1:0]   key_t;
    typedef logic [`DB_VALUE_W-1:0] value_t;
    typedef logic [`DB_FILL_W-1:0]  fill_t;

    // One stash slot
    typedef struct packed {
        key_t   key;
        value_t value;
    } db_entry_t;

    // Occupancy as seen by the controller and the store
    typedef struct packed {
        fill_t fill;
        logic  empty;
        logic  full;
        logic  init_done;
    } db_status_t;

    // --------------------------------------------------
    // Command strobes, encoding matches CMD bits 2:0
    // --------------------------------------------------
    typedef enum logic [2:0] {
        NONE   = 3'd0,
        PUSH   = 3'd1,
        POP    = 3'd2,
        LOOKUP = 3'd3,
        INIT   = 3'd4
    } db_cmd_t;

    typedef enum logic [1:0] {IDLE, ACCESS, EXEC, DONE} db_ctrl_state_t;

endpackage : db_pkg

`default_nettype wire

// ==== hdl/db_stash_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "db_stash_cfg.svh"

module db_stash_ctrl_fsm
    import db_pkg::*;
    import apb_pkg::*;
(
    input  logic       clk,
    input  logic       __srst,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    output db_cmd_t    cmd,
    output db_entry_t  wr_entry,
    input  db_status_t status,
    input  logic       lookup_hit,
    input  value_t     lookup_value,
    input  db_entry_t  tail_entry
);

    db_ctrl_state_t state;

    logic      pready_q;
    logic      pslverr_q;
    apb_data_t prdata_q;

    db_entry_t rd_entry;
    logic      hit_q;
    logic      error_q;

    logic      setup;
    logic      cmd_wr;
    logic      addr_ok;
    apb_data_t rd_data;
    db_cmd_t   req_cmd;
    logic      reject;

    // --------------------------------------------------
    // Decode and read mux
    // --------------------------------------------------
    assign setup  = apb_req.psel && !apb_req.penable;
    assign cmd_wr = apb_req.pwrite && (apb_req.paddr == `DB_REG_CMD);

    always_comb begin
        rd_data = '0;
        addr_ok = 1'b1;
        case (apb_req.paddr)
            `DB_REG_KEY:      rd_data = apb_data_t'(wr_entry.key);
            `DB_REG_VALUE:    rd_data = apb_data_t'(wr_entry.value);
            `DB_REG_CMD:      rd_data = '0;
            // Fill in the low bits, flags above it
            `DB_REG_STATUS:   rd_data = apb_data_t'({error_q, hit_q, status.init_done,
                                                     status.full, status.empty, status.fill});
            `DB_REG_RD_KEY:   rd_data = apb_data_t'(rd_entry.key);
            `DB_REG_RD_VALUE: rd_data = apb_data_t'(rd_entry.value);
            default:          addr_ok = 1'b0;
        endcase
    end

    // Overflow and underflow never reach the datapath
    always_comb begin
        req_cmd = NONE;
        reject  = 1'b0;
        case (db_cmd_t'(apb_req.pwdata[2:0]))
            NONE:   req_cmd = NONE;
            PUSH:   if (status.full) reject = 1'b1; else req_cmd = PUSH;
            POP:    if (status.empty) reject = 1'b1; else req_cmd = POP;
            LOOKUP: req_cmd = LOOKUP;
            INIT:   req_cmd = INIT;
            default: reject = 1'b1;
        endcase
    end

    // --------------------------------------------------
    // APB phase tracking
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            state     <= IDLE;
            cmd       <= NONE;
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
            hit_q     <= 1'b0;
            error_q   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (setup && cmd_wr) begin
                        // Strobe lands in the first access cycle
                        state   <= EXEC;
                        cmd     <= req_cmd;
                        error_q <= reject;
                    end else if (setup) begin
                        state     <= ACCESS;
                        pready_q  <= 1'b1;
                        pslverr_q <= !addr_ok;
                    end
                end
                ACCESS: begin
                    state     <= IDLE;
                    pready_q  <= 1'b0;
                    pslverr_q <= 1'b0;
                end
                EXEC: begin
                    state    <= DONE;
                    cmd      <= NONE;
                    hit_q    <= (cmd == LOOKUP) && lookup_hit;
                    pready_q <= 1'b1;
                end
                DONE: begin
                    state    <= IDLE;
                    pready_q <= 1'b0;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Data registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if ((state == IDLE) && setup) begin
            prdata_q <= rd_data;
        end
        if ((state == ACCESS) && apb_req.pwrite) begin
            if (apb_req.paddr == `DB_REG_KEY) begin
                wr_entry.key <= apb_req.pwdata[`DB_KEY_W-1:0];
            end
            if (apb_req.paddr == `DB_REG_VALUE) begin
                wr_entry.value <= apb_req.pwdata[`DB_VALUE_W-1:0];
            end
        end
        // Tail and lookup result still valid during the strobe
        if ((state == EXEC) && (cmd == POP)) begin
            rd_entry <= tail_entry;
        end else if ((state == EXEC) && (cmd == LOOKUP)) begin
            rd_entry.key   <= wr_entry.key;
            rd_entry.value <= lookup_value;
        end
    end

    always_comb begin
        apb_rsp.pready  = pready_q;
        apb_rsp.prdata  = prdata_q;
        apb_rsp.pslverr = pslverr_q;
    end

endmodule : db_stash_ctrl_fsm

`default_nettype wire

// ==== hdl/db_fill_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "db_stash_cfg.svh"

module db_fill_counter
    import db_pkg::*;
(
    input  logic       clk,
    input  logic       __srst,
    input  db_cmd_t    cmd,
    output db_status_t status
);

    fill_t fill_q;
    logic  init_done_q;

    // --------------------------------------------------
    // Occupancy count
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst || (cmd == INIT)) begin
            fill_q <= '0;
        end else if (cmd == PUSH) begin
            fill_q <= fill_q + 1'b1;
        end else if (cmd == POP) begin
            fill_q <= fill_q - 1'b1;
        end
    end

    // Low for one cycle after any clear
    always_ff @(posedge clk) begin
        if (__srst || (cmd == INIT)) begin
            init_done_q <= 1'b0;
        end else begin
            init_done_q <= 1'b1;
        end
    end

    always_comb begin
        status.fill      = fill_q;
        status.empty     = (fill_q == '0);
        status.full      = (fill_q == fill_t'(`DB_STASH_SIZE));
        status.init_done = init_done_q;
    end

endmodule : db_fill_counter

`default_nettype wire

// ==== hdl/db_stash_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "db_stash_cfg.svh"

module db_stash_store
    import db_pkg::*;
(
    input  logic       clk,
    input  db_cmd_t    cmd,
    input  db_entry_t  wr_entry,
    input  db_status_t status,
    output logic       lookup_hit,
    output value_t     lookup_value,
    output db_entry_t  tail_entry
);

    localparam int IDX_W = $clog2(`DB_STASH_SIZE);

    typedef logic [IDX_W-1:0] idx_t;

    // Index 0 is the newest entry
    db_entry_t entries [`DB_STASH_SIZE];

    logic [`DB_STASH_SIZE-1:0] occupied;
    idx_t                      tail_idx;

    // --------------------------------------------------
    // Entry array
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (cmd == PUSH) begin
            for (int i = `DB_STASH_SIZE - 1; i > 0; i--) begin
                entries[i] <= entries[i-1];
            end
            entries[0] <= wr_entry;
        end else if (cmd == INIT) begin
            for (int i = 0; i < `DB_STASH_SIZE; i++) begin
                entries[i] <= '0;
            end
        end
        // Pop frees the tail via the counter alone
    end

    // Slots below the fill level hold data
    always_comb begin
        for (int i = 0; i < `DB_STASH_SIZE; i++) begin
            occupied[i] = (fill_t'(i) < status.fill);
        end
    end

    // --------------------------------------------------
    // Key search
    // --------------------------------------------------
    // Scan from the oldest so the lowest matching index wins
    always_comb begin
        lookup_hit   = 1'b0;
        lookup_value = '0;
        for (int i = `DB_STASH_SIZE - 1; i >= 0; i--) begin
            if (occupied[i] && (entries[i].key == wr_entry.key)) begin
                lookup_hit   = 1'b1;
                lookup_value = entries[i].value;
            end
        end
    end

    // --------------------------------------------------
    // Tail readout
    // --------------------------------------------------
    assign tail_idx = idx_t'(status.fill - 1'b1);

    // Index wraps when empty, so mask it
    always_comb begin
        if (status.empty) begin
            tail_entry = '0;
        end else begin
            tail_entry = entries[tail_idx];
        end
    end

endmodule : db_stash_store

`default_nettype wire

// ==== hdl/db_stash_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module db_stash_top
    import db_pkg::*;
    import apb_pkg::*;
(
    input  logic     clk,
    input  logic     __srst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    db_cmd_t    cmd;
    db_entry_t  wr_entry;
    db_status_t status;
    logic       lookup_hit;
    value_t     lookup_value;
    db_entry_t  tail_entry;

    // --------------------------------------------------
    // APB front end and command checks
    // --------------------------------------------------
    db_stash_ctrl_fsm ctrl_fsm_i (
        .clk          (clk),
        .__srst       (__srst),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .cmd          (cmd),
        .wr_entry     (wr_entry),
        .status       (status),
        .lookup_hit   (lookup_hit),
        .lookup_value (lookup_value),
        .tail_entry   (tail_entry)
    );

    // Fill level and flags
    db_fill_counter fill_counter_i (
        .clk    (clk),
        .__srst (__srst),
        .cmd    (cmd),
        .status (status)
    );

    // Entry storage and search
    db_stash_store store_i (
        .clk          (clk),
        .cmd          (cmd),
        .wr_entry     (wr_entry),
        .status       (status),
        .lookup_hit   (lookup_hit),
        .lookup_value (lookup_value),
        .tail_entry   (tail_entry)
    );

endmodule : db_stash_top

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic __srst
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 8;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release lands just after an edge, like the other inputs
    initial begin
        __srst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        __srst = 1'b0;
    end

endmodule : tb_clk_gen

`default_nettype wire

// ==== tb/db_stash_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "db_stash_cfg.svh"

module db_stash_assert
    import db_pkg::*;
    import apb_pkg::*;
(
    input logic           clk,
    input logic           __srst,
    input apb_req_t       apb_req,
    input apb_rsp_t       apb_rsp,
    input db_cmd_t        cmd,
    input db_status_t     status,
    input db_ctrl_state_t state
);

    // Failures seen so far
    int fail_count = 0;

    logic cmd_setup;

    assign cmd_setup = (state == IDLE) && apb_req.psel && !apb_req.penable
                       && apb_req.pwrite && (apb_req.paddr == `DB_REG_CMD);

    // --------------------------------------------------
    // APB timing
    // --------------------------------------------------
    ready_in_access: assert property (@(posedge clk) disable iff (__srst)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
    else begin
        fail_count++;
        $error("pready high outside an APB access phase");
    end

    // First access cycle of a CMD write is the wait state
    cmd_wait_state: assert property (@(posedge clk) disable iff (__srst)
        cmd_setup |=> !apb_rsp.pready)
    else begin
        fail_count++;
        $error("CMD write did not insert its wait state");
    end

    cmd_ready: assert property (@(posedge clk) disable iff (__srst)
        $past(cmd_setup) |=> apb_rsp.pready)
    else begin
        fail_count++;
        $error("CMD write not completed after one wait state");
    end

    // --------------------------------------------------
    // Occupancy and strobes
    // --------------------------------------------------
    fill_bound: assert property (@(posedge clk) disable iff (__srst)
        status.fill <= fill_t'(`DB_STASH_SIZE))
    else begin
        fail_count++;
        $error("Fill count above stash size");
    end

    fill_only_on_strobe: assert property (@(posedge clk) disable iff (__srst)
        (status.fill != $past(status.fill)) |-> ($past(cmd) != NONE))
    else begin
        fail_count++;
        $error("Fill count changed without a command strobe");
    end

    fill_single_step: assert property (@(posedge clk) disable iff (__srst)
        (($past(cmd) == PUSH) || ($past(cmd) == POP)) |->
        ((status.fill - $past(status.fill) == fill_t'(1))
         || ($past(status.fill) - status.fill == fill_t'(1))))
    else begin
        fail_count++;
        $error("Fill count moved by more than one on a strobe");
    end

    strobe_one_cycle: assert property (@(posedge clk) disable iff (__srst)
        (cmd != NONE) |=> (cmd == NONE))
    else begin
        fail_count++;
        $error("Command strobe held longer than one cycle");
    end

endmodule : db_stash_assert

`default_nettype wire

// ==== tb/db_stash_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "db_stash_cfg.svh"

module db_stash_tb
    import db_pkg::*;
    import apb_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20;
    localparam int DRIVE_DLY      = 2;

    logic        clk;
    logic        __srst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] lfsr_state;
    int          check_errors;
    int          timeout_errors;

    // Reference model, index 0 is the newest entry
    db_entry_t   model_q[$];
    logic        model_hit;
    logic        model_error;

    tb_clk_gen clk_gen_i (
        .clk    (clk),
        .__srst (__srst)
    );

    db_stash_top dut_i (
        .clk     (clk),
        .__srst  (__srst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    bind db_stash_top db_stash_assert assert_i (
        .clk     (clk),
        .__srst  (__srst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .cmd     (cmd),
        .status  (status),
        .state   (ctrl_fsm_i.state)
    );

    // --------------------------------------------------
    // Random source, taps 32 22 2 1
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] cur);
        return {cur[30:0], cur[31] ^ cur[21] ^ cur[1] ^ cur[0]};
    endfunction

    task automatic random_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input apb_data_t expected,
                               input apb_data_t actual);
        assert (actual === expected) else begin
            check_errors++;
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(posedge clk);
        #DRIVE_DLY;
        while (__srst && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end
        if (__srst) begin
            timeout_errors++;
            $display("Reset still asserted after %0d cycles", TIMEOUT_CYCLES);
        end
    endtask

    // --------------------------------------------------
    // APB host
    // --------------------------------------------------
    task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output int waits, output logic slverr);
        int cycles;
        cycles = 0;
        rdata  = '0;
        waits  = 0;
        slverr = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DLY;
        apb_req.penable = 1'b1;
        while (!apb_rsp.pready && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end
        if (apb_rsp.pready) begin
            waits  = cycles;
            rdata  = apb_rsp.prdata;
            slverr = apb_rsp.pslverr;
        end else begin
            timeout_errors++;
            $display("No pready within %0d cycles at address 0x%02h", TIMEOUT_CYCLES, addr);
        end
        // Transfer completes on this edge
        @(posedge clk);
        #DRIVE_DLY;
        apb_req = '0;
    endtask

    task automatic reg_write(input string name, input apb_addr_t addr, input apb_data_t data);
        apb_data_t rdata;
        int        waits;
        logic      slverr;
        apb_transfer(1'b1, addr, data, rdata, waits, slverr);
        check_value({name, " wait states"}, 0, waits);
        check_value({name, " pslverr"}, 0, apb_data_t'(slverr));
    endtask

    task automatic reg_read(input string name, input apb_addr_t addr, output apb_data_t data);
        int   waits;
        logic slverr;
        apb_transfer(1'b0, addr, '0, data, waits, slverr);
        check_value({name, " wait states"}, 0, waits);
        check_value({name, " pslverr"}, 0, apb_data_t'(slverr));
    endtask

    task automatic run_cmd(input string name, input db_cmd_t code);
        apb_data_t rdata;
        int        waits;
        logic      slverr;
        apb_transfer(1'b1, `DB_REG_CMD, apb_data_t'(code), rdata, waits, slverr);
        check_value({name, " cmd wait states"}, 1, waits);
        check_value({name, " cmd pslverr"}, 0, apb_data_t'(slverr));
    endtask

    // --------------------------------------------------
    // Model and checked operations
    // --------------------------------------------------
    // STATUS layout: fill, empty, full, init_done, hit, error
    function automatic apb_data_t expected_status();
        apb_data_t s;
        s = '0;
        s[`DB_FILL_W-1:0] = fill_t'(model_q.size());
        s[`DB_FILL_W]     = (model_q.size() == 0);
        s[`DB_FILL_W+1]   = (model_q.size() == `DB_STASH_SIZE);
        s[`DB_FILL_W+2]   = 1'b1;
        s[`DB_FILL_W+3]   = model_hit;
        s[`DB_FILL_W+4]   = model_error;
        return s;
    endfunction

    function automatic logic model_lookup(input key_t key, output value_t value);
        logic found;
        found = 1'b0;
        value = '0;
        foreach (model_q[i]) begin
            if (!found && (model_q[i].key == key)) begin
                found = 1'b1;
                value = model_q[i].value;
            end
        end
        return found;
    endfunction

    task automatic check_status(input string name);
        apb_data_t data;
        reg_read({name, " status read"}, `DB_REG_STATUS, data);
        check_value({name, " status"}, expected_status(), data);
    endtask

    task automatic push_entry(input string name, input key_t key, input value_t value);
        db_entry_t entry;
        entry.key   = key;
        entry.value = value;
        reg_write({name, " key write"}, `DB_REG_KEY, apb_data_t'(key));
        reg_write({name, " value write"}, `DB_REG_VALUE, apb_data_t'(value));
        run_cmd(name, PUSH);
        model_hit   = 1'b0;
        model_error = (model_q.size() == `DB_STASH_SIZE);
        if (!model_error) begin
            model_q.push_front(entry);
        end
        check_status(name);
    endtask

    task automatic push_random(input string name, output key_t key);
        logic [31:0] bits;
        random_bits(`DB_KEY_W, bits);
        key = key_t'(bits);
        random_bits(`DB_VALUE_W, bits);
        push_entry(name, key, value_t'(bits));
    endtask

    task automatic pop_entry(input string name);
        db_entry_t oldest;
        apb_data_t data;
        run_cmd(name, POP);
        model_hit   = 1'b0;
        model_error = (model_q.size() == 0);
        if (!model_error) begin
            oldest = model_q.pop_back();
            reg_read({name, " rd_key read"}, `DB_REG_RD_KEY, data);
            check_value({name, " rd_key"}, apb_data_t'(oldest.key), data);
            reg_read({name, " rd_value read"}, `DB_REG_RD_VALUE, data);
            check_value({name, " rd_value"}, apb_data_t'(oldest.value), data);
        end
        check_status(name);
    endtask

    task automatic lookup_key(input string name, input key_t key);
        value_t    expected;
        apb_data_t data;
        model_hit   = model_lookup(key, expected);
        model_error = 1'b0;
        reg_write({name, " key write"}, `DB_REG_KEY, apb_data_t'(key));
        run_cmd(name, LOOKUP);
        reg_read({name, " rd_key read"}, `DB_REG_RD_KEY, data);
        check_value({name, " rd_key"}, apb_data_t'(key), data);
        reg_read({name, " rd_value read"}, `DB_REG_RD_VALUE, data);
        check_value({name, " rd_value"}, apb_data_t'(expected), data);
        check_status(name);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] bits;
        key_t        key;
        key_t        dup_key;
        value_t      scratch_value;
        apb_data_t   data;
        int          waits;
        logic        slverr;
        int          assert_errors;
        apb_req        = '0;
        lfsr_state     = 32'd32;
        check_errors   = 0;
        timeout_errors = 0;
        model_hit      = 1'b0;
        model_error    = 1'b0;
        wait_reset_release();

        check_status("reset");

        // Plain registers and decode
        random_bits(`DB_KEY_W, bits);
        reg_write("key reg write", `DB_REG_KEY, bits);
        reg_read("key reg read", `DB_REG_KEY, data);
        check_value("key readback", bits, data);
        random_bits(`DB_VALUE_W, bits);
        reg_write("value reg write", `DB_REG_VALUE, bits);
        reg_read("value reg read", `DB_REG_VALUE, data);
        check_value("value readback", bits, data);
        apb_transfer(1'b0, 8'h18, '0, data, waits, slverr);
        check_value("unmapped wait states", 0, waits);
        check_value("unmapped pslverr", 1, apb_data_t'(slverr));

        for (int i = 0; i < `DB_STASH_SIZE; i++) begin
            push_random("fill", key);
        end
        push_random("overflow", key);

        for (int i = 0; i < `DB_STASH_SIZE; i++) begin
            pop_entry("drain");
        end
        pop_entry("underflow");

        // Repeated key, the later push must win
        push_random("lookup first", dup_key);
        push_random("lookup second", key);
        random_bits(`DB_VALUE_W, bits);
        push_entry("lookup repeat", dup_key, value_t'(bits));
        lookup_key("lookup present", key);
        lookup_key("lookup newest", dup_key);
        key = dup_key + 1'b1;
        while (model_lookup(key, scratch_value)) begin
            key = key + 1'b1;
        end
        lookup_key("lookup absent", key);

        run_cmd("init", INIT);
        model_q.delete();
        model_hit   = 1'b0;
        model_error = 1'b0;
        check_status("init");

        assert_errors = dut_i.assert_i.fail_count;
        $display("Errors: %0d check, %0d timeout, %0d assertion",
                 check_errors, timeout_errors, assert_errors);
        if (check_errors + timeout_errors + assert_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : db_stash_tb

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/apb_pkg.sv
hdl/db_pkg.sv
hdl/db_stash_ctrl_fsm.sv
hdl/db_fill_counter.sv
hdl/db_stash_store.sv
hdl/db_stash_top.sv
tb/tb_clk_gen.sv
tb/db_stash_assert.sv
tb/db_stash_tb.sv

// ==== Makefile ====
TOP := db_stash_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
